/* project.f */
rp_pkg.sv
pll_lock_monitor.sv
adc_loopback_switch.sv
dac_output_stage.sv
trigger_router.sv
rp_analog_top.sv
tb_rp_analog.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
# Exit status is nonzero when the build fails, the run fails,
# or the log holds the fail message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_rp_analog
LOG_FILE=sim.log
FAIL_MSG="Some tests failed"

echo "building with verilator"
verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_rp_analog \
  -Mdir "${BUILD_DIR}" \
  -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

echo "running simulation"
"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
run_status=$?
cat "${LOG_FILE}"

if [ ${run_status} -ne 0 ]; then
  echo "simulation exited with status ${run_status}"
  exit 1
fi

if grep -q "${FAIL_MSG}" "${LOG_FILE}"; then
  echo "failure reported in ${LOG_FILE}"
  exit 1
fi

echo "simulation finished without reported failures"
exit 0

/* tb_rp_analog.sv */
// directed testbench for the analog datapath and trigger glue
// inputs change 1 ns after the rising edge, checks run at the same point
// before the next drive, so every output has had a full cycle to settle
// random values come from $urandom with a fixed seed

`timescale 1ns/100ps

module tb_rp_analog;

  localparam int CLK_PERIOD  = 4;
  localparam int TEST_CYCLES = 10 + 60 + 210 + 50 + 30;       // rough sum per test
  localparam int WATCHDOG_NS = TEST_CYCLES * 2 * CLK_PERIOD;

  logic                        adc_clk;
  logic                        rst_n_i;
  logic                        pll_locked_i;
  logic                        idly_rdy_i;
  logic                        digital_loop_i;
  logic [rp_pkg::MODE_W-1:0]   daisy_mode_i;
  logic [rp_pkg::ADC_DW-1:0]   adc_raw_a_i;
  logic [rp_pkg::ADC_DW-1:0]   adc_raw_b_i;
  logic [rp_pkg::DAC_DW-1:0]   gen_a_i;
  logic [rp_pkg::DAC_DW-1:0]   gen_b_i;
  logic [rp_pkg::DAC_DW-1:0]   fb_a_i;
  logic [rp_pkg::DAC_DW-1:0]   fb_b_i;
  logic                        trig_i;
  logic                        scope_trig_i;
  logic                        asg_trig_i;
  logic [rp_pkg::DAISY_DW-1:0] daisy_rx_dat_i;
  logic                        daisy_rx_rdy_i;
  logic                        core_rstn_o;
  logic                        dac_reset_o;
  logic [rp_pkg::DIAG_DW-1:0]  unlock_cnt_o;
  logic [rp_pkg::SMP_DW-1:0]   smp_a_o;
  logic [rp_pkg::SMP_DW-1:0]   smp_b_o;
  logic [rp_pkg::DAC_DW-1:0]   dac_dat_a_o;
  logic [rp_pkg::DAC_DW-1:0]   dac_dat_b_o;
  logic                        trig_ext_o;
  logic                        trig_out_o;
  logic [rp_pkg::DAISY_DW-1:0] daisy_tx_dat_o;
  logic                        daisy_tx_dv_o;

  int errors = 0;
  int checks = 0;

  rp_analog_top uut (.*);

  ////////////////////////////////////////////////////////////////////////////
  // clock, watchdog and helpers
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  // one edge, then the drive offset
  task automatic step();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // signed add, clip to the 14-bit range, invert only the in-range result
  function automatic logic [13:0] dac_word(input logic [13:0] gen, input logic [13:0] fb);
    int          s;
    logic [31:0] u;
    s = int'($signed(gen)) + int'($signed(fb));
    u = s;
    if (s > 8191) return 14'h1FFF;        // positive clip
    else if (s < -8192) return 14'h2000;  // negative clip
    return ~u[13:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_gating();
    check_val("core_rstn_o", 32'(0), 32'(core_rstn_o));  // still in reset
    check_val("dac_reset_o", 32'(1), 32'(dac_reset_o));
    rst_n_i = 1'b1;
    step();
    check_val("core_rstn_o", 32'(1), 32'(core_rstn_o));  // one cycle after release
    check_val("dac_reset_o", 32'(1), 32'(dac_reset_o));
    step();
    check_val("dac_reset_o", 32'(0), 32'(dac_reset_o));  // one more cycle
    idly_rdy_i = 1'b0;
    step();
    check_val("core_rstn_o", 32'(0), 32'(core_rstn_o));  // delay line lost
    idly_rdy_i = 1'b1;
    step();
    check_val("core_rstn_o", 32'(1), 32'(core_rstn_o));
    step();
  endtask

  task automatic test_unlock_counter();
    logic [31:0] r;
    int          n;
    r = $urandom;
    n = 10 + int'(r % 31);
    check_val("unlock_cnt_o", 32'(0), unlock_cnt_o);  // locked since reset
    pll_locked_i = 1'b0;
    repeat (n) step();
    check_val("unlock_cnt_o", 32'(n), unlock_cnt_o);
    pll_locked_i = 1'b1;
    repeat (5) step();
    check_val("unlock_cnt_o", 32'(n), unlock_cnt_o);  // holds while locked
  endtask

  task automatic test_dac_path();
    logic [13:0] exp_a[$];  // 2-deep pipe model, ch a
    logic [13:0] exp_b[$];
    logic [31:0] r1;
    logic [31:0] r2;
    for (int i = 0; i < 202; i++) begin
      step();
      if (i >= 2) begin
        check_val("dac_dat_b_o", 32'(exp_a.pop_front()), 32'(dac_dat_b_o));  // ch a
        check_val("dac_dat_a_o", 32'(exp_b.pop_front()), 32'(dac_dat_a_o));  // ch b
      end
      if (i < 200) begin
        r1 = $urandom;
        r2 = $urandom;
        if (i % 10 == 3) begin         // force positive overflow
          gen_a_i = 14'h1000 | 14'(r1[11:0]);
          fb_a_i  = 14'h1000 | 14'(r2[11:0]);
          gen_b_i = 14'h1000 | 14'(r2[23:12]);
          fb_b_i  = 14'h1000 | 14'(r1[23:12]);
        end else if (i % 10 == 7) begin  // force negative overflow
          gen_a_i = 14'h2000 | 14'(r1[11:0]);
          fb_a_i  = 14'h2000 | 14'(r2[11:0]);
          gen_b_i = 14'h2000 | 14'(r2[23:12]);
          fb_b_i  = 14'h2000 | 14'(r1[23:12]);
        end else begin
          gen_a_i = r1[13:0];
          fb_a_i  = r1[29:16];
          gen_b_i = r2[13:0];
          fb_b_i  = r2[29:16];
        end
        exp_a.push_back(dac_word(gen_a_i, fb_a_i));
        exp_b.push_back(dac_word(gen_b_i, fb_b_i));
      end
    end
  endtask

  task automatic test_adc_switch();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [13:0] wa;
    logic [13:0] wb;
    digital_loop_i = 1'b0;
    repeat (20) begin
      r1 = $urandom;
      adc_raw_a_i = r1[13:0];
      adc_raw_b_i = r1[29:16];
      step();
      check_val("smp_a_o", 32'(adc_raw_b_i[13:2]), 32'(smp_a_o));  // crossed
      check_val("smp_b_o", 32'(adc_raw_a_i[13:2]), 32'(smp_b_o));
    end
    digital_loop_i = 1'b1;
    repeat (20) begin
      r1 = $urandom;
      r2 = $urandom;
      gen_a_i = r1[13:0];
      fb_a_i  = r1[29:16];
      gen_b_i = r2[13:0];
      fb_b_i  = r2[29:16];
      wa = dac_word(gen_a_i, fb_a_i);
      wb = dac_word(gen_b_i, fb_b_i);
      step();
      check_val("smp_a_o", 32'(wa[13:2]), 32'(smp_a_o));  // looped back
      check_val("smp_b_o", 32'(wb[13:2]), 32'(smp_b_o));
    end
    digital_loop_i = 1'b0;
  endtask

  task automatic test_triggers();
    logic [31:0] r;
    logic        exp_out;
    // sync mode, chain trigger masks the local pin one cycle later
    daisy_mode_i   = 3'b001;
    trig_i         = 1'b1;
    daisy_rx_dat_i = '0;
    step();
    check_val("trig_ext_o", 32'(1), 32'(trig_ext_o));
    daisy_rx_dat_i = 16'h0100;
    #1;
    check_val("trig_ext_o", 32'(1), 32'(trig_ext_o));  // not yet registered
    step();
    check_val("trig_ext_o", 32'(0), 32'(trig_ext_o));
    daisy_mode_i = 3'b000;  // mask only acts in sync mode
    #1;
    check_val("trig_ext_o", 32'(1), 32'(trig_ext_o));
    daisy_rx_dat_i = '0;
    step();
    // output select and transmit word, every mode combination
    for (int k = 0; k < 8; k++) begin
      r = $urandom;
      daisy_mode_i   = {k[1], 1'b0, k[0]};
      daisy_rx_rdy_i = k[2];
      asg_trig_i     = r[0];
      scope_trig_i   = ~r[0];  // opposite of asg, so either pick shows
      trig_i         = r[2];
      exp_out        = k[1] ? r[0] : ~r[0];
      step();
      check_val("trig_out_o", 32'(exp_out), 32'(trig_out_o));
      check_val("trig_ext_o", 32'(trig_i), 32'(trig_ext_o));
      if (k[0]) begin
        check_val("daisy_tx_dat_o", 32'({16{exp_out}}), 32'(daisy_tx_dat_o));
        check_val("daisy_tx_dv_o", 32'(0), 32'(daisy_tx_dv_o));
      end else begin
        check_val("daisy_tx_dat_o", 32'(16'h1234), 32'(daisy_tx_dat_o));  // idle pattern
        check_val("daisy_tx_dv_o", 32'(k[2]), 32'(daisy_tx_dv_o));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(49666));
    rst_n_i        = 1'b0;
    pll_locked_i   = 1'b1;
    idly_rdy_i     = 1'b1;
    digital_loop_i = 1'b0;
    daisy_mode_i   = '0;
    adc_raw_a_i    = '0;
    adc_raw_b_i    = '0;
    gen_a_i        = '0;
    gen_b_i        = '0;
    fb_a_i         = '0;
    fb_b_i         = '0;
    trig_i         = 1'b0;
    scope_trig_i   = 1'b0;
    asg_trig_i     = 1'b0;
    daisy_rx_dat_i = '0;
    daisy_rx_rdy_i = 1'b0;
    repeat (2) step();  // reset for 2 cycles
    test_reset_gating();
    test_unlock_counter();
    test_dac_path();
    test_adc_switch();
    test_triggers();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* rp_analog_top.sv */
// analog datapath and trigger glue, single adc_clk domain
// adc words arrive parallel, deserialisation is outside this block
// configuration inputs are plain static levels
// all blocks run off rst_n_i, core_rstn_o is only passed out

`timescale 1ns/100ps

module rp_analog_top (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,
  // clock and delay status
  input  logic                        pll_locked_i,
  input  logic                        idly_rdy_i,
  // configuration
  input  logic                        digital_loop_i,
  input  logic [rp_pkg::MODE_W-1:0]   daisy_mode_i,
  // adc
  input  logic [rp_pkg::ADC_DW-1:0]   adc_raw_a_i,
  input  logic [rp_pkg::ADC_DW-1:0]   adc_raw_b_i,
  // generator and feedback samples
  input  logic [rp_pkg::DAC_DW-1:0]   gen_a_i,
  input  logic [rp_pkg::DAC_DW-1:0]   gen_b_i,
  input  logic [rp_pkg::DAC_DW-1:0]   fb_a_i,
  input  logic [rp_pkg::DAC_DW-1:0]   fb_b_i,
  // triggers and daisy
  input  logic                        trig_i,
  input  logic                        scope_trig_i,
  input  logic                        asg_trig_i,
  input  logic [rp_pkg::DAISY_DW-1:0] daisy_rx_dat_i,
  input  logic                        daisy_rx_rdy_i,
  // resets and diagnostics
  output logic                        core_rstn_o,
  output logic                        dac_reset_o,
  output logic [rp_pkg::DIAG_DW-1:0]  unlock_cnt_o,
  // acquisition samples
  output logic [rp_pkg::SMP_DW-1:0]   smp_a_o,
  output logic [rp_pkg::SMP_DW-1:0]   smp_b_o,
  // dac pins
  output logic [rp_pkg::DAC_DW-1:0]   dac_dat_a_o,
  output logic [rp_pkg::DAC_DW-1:0]   dac_dat_b_o,
  // trigger and daisy out
  output logic                        trig_ext_o,
  output logic                        trig_out_o,
  output logic [rp_pkg::DAISY_DW-1:0] daisy_tx_dat_o,
  output logic                        daisy_tx_dv_o
);

  logic [rp_pkg::DAC_DW-1:0] loop_a;  // saturated dac word ch a, to switch
  logic [rp_pkg::DAC_DW-1:0] loop_b;  // saturated dac word ch b, to switch

  ////////////////////////////////////////////////////////////////////////////
  // reset and diagnostics
  ////////////////////////////////////////////////////////////////////////////

  pll_lock_monitor i_lock (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .idly_rdy_i   (idly_rdy_i),
    .core_rstn_o  (core_rstn_o),
    .dac_reset_o  (dac_reset_o),
    .unlock_cnt_o (unlock_cnt_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // dac and adc paths
  ////////////////////////////////////////////////////////////////////////////

  dac_output_stage i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .gen_a_i     (gen_a_i),
    .gen_b_i     (gen_b_i),
    .fb_a_i      (fb_a_i),
    .fb_b_i      (fb_b_i),
    .loop_a_o    (loop_a),
    .loop_b_o    (loop_b),
    .dac_dat_a_o (dac_dat_a_o),  // carries ch b
    .dac_dat_b_o (dac_dat_b_o)   // carries ch a
  );

  // loopback taps the comb dac words, so 1 cycle from generator input
  adc_loopback_switch i_sw (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .digital_loop_i (digital_loop_i),
    .adc_raw_a_i    (adc_raw_a_i),
    .adc_raw_b_i    (adc_raw_b_i),
    .loop_a_i       (loop_a),
    .loop_b_i       (loop_b),
    .smp_a_o        (smp_a_o),
    .smp_b_o        (smp_b_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // triggers
  ////////////////////////////////////////////////////////////////////////////

  trigger_router i_trig (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .trig_i         (trig_i),
    .daisy_mode_i   (daisy_mode_i),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .daisy_rx_dat_i (daisy_rx_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .trig_ext_o     (trig_ext_o),
    .trig_out_o     (trig_out_o),
    .daisy_tx_dat_o (daisy_tx_dat_o),
    .daisy_tx_dv_o  (daisy_tx_dv_o)
  );

endmodule

/* trigger_router.sv */
// external trigger masking and daisy chain transmit glue
// daisy receive word is taken as already in the adc_clk domain
// trig_ext_o and the transmit word are combinational on config levels
// mode bit 1 drives a connector pin on the board and is ignored here

`timescale 1ns/100ps

module trigger_router (
  input  logic                        adc_clk,
  input  logic                        rst_n_i,
  input  logic                        trig_i,          // external trigger pin
  input  logic [rp_pkg::MODE_W-1:0]   daisy_mode_i,    // daisy mode config
  input  logic                        scope_trig_i,    // scope trigger out
  input  logic                        asg_trig_i,      // generator trigger out
  input  logic [rp_pkg::DAISY_DW-1:0] daisy_rx_dat_i,  // daisy parallel rx word
  input  logic                        daisy_rx_rdy_i,  // daisy link ready
  output logic                        trig_ext_o,      // masked ext trigger
  output logic                        trig_out_o,      // trigger leaving the board
  output logic [rp_pkg::DAISY_DW-1:0] daisy_tx_dat_o,  // daisy parallel tx word
  output logic                        daisy_tx_dv_o    // daisy tx valid
);

  logic daisy_trig;  // any rx bit set, registered
  logic sync_mode;   // trigger travels over the link

  assign sync_mode = daisy_mode_i[rp_pkg::MODE_SYNC_BIT];

  ////////////////////////////////////////////////////////////////////////////
  // receive side
  ////////////////////////////////////////////////////////////////////////////

  // in sync mode the upstream board sends its trigger on every bit
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      daisy_trig <= 1'b0;
    end else begin
      daisy_trig <= |daisy_rx_dat_i;
    end
  end

  // local pin is blocked while the chain trigger is active
  assign trig_ext_o = trig_i & ~(sync_mode & daisy_trig);

  ////////////////////////////////////////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////////////////////////////////////////

  assign trig_out_o = daisy_mode_i[rp_pkg::MODE_TRIG_SEL_BIT] ? asg_trig_i
                                                               : scope_trig_i;

  // sync: replicate trigger on all bits, else fixed idle pattern
  always_comb begin
    if (sync_mode) begin
      daisy_tx_dat_o = {rp_pkg::DAISY_DW{trig_out_o}};
      daisy_tx_dv_o  = 1'b0;  // no valid framing in sync mode
    end else begin
      daisy_tx_dat_o = rp_pkg::DAISY_IDLE_WORD;
      daisy_tx_dv_o  = daisy_rx_rdy_i;  // echo link ready
    end
  end

endmodule

/* dac_output_stage.sv */
// dac output stage, generator plus feedback per channel
// inputs are signed 14-bit two's complement
// output is saturated, then inverted to the converter's coding
// saturated words are left uninverted, as on the board
// dac_dat_a_o carries channel b and dac_dat_b_o channel a, 2 cycles late

`timescale 1ns/100ps

module dac_output_stage (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  input  logic [rp_pkg::DAC_DW-1:0] gen_a_i,      // generator ch a
  input  logic [rp_pkg::DAC_DW-1:0] gen_b_i,      // generator ch b
  input  logic [rp_pkg::DAC_DW-1:0] fb_a_i,       // feedback ch a
  input  logic [rp_pkg::DAC_DW-1:0] fb_b_i,       // feedback ch b
  output logic [rp_pkg::DAC_DW-1:0] loop_a_o,     // comb saturated word ch a
  output logic [rp_pkg::DAC_DW-1:0] loop_b_o,     // comb saturated word ch b
  output logic [rp_pkg::DAC_DW-1:0] dac_dat_a_o,  // dac a pins, ch b data
  output logic [rp_pkg::DAC_DW-1:0] dac_dat_b_o   // dac b pins, ch a data
);

  logic [rp_pkg::DAC_DW-1:0] dac_a_q;  // first stage ch a
  logic [rp_pkg::DAC_DW-1:0] dac_b_q;  // first stage ch b

  ////////////////////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  // sign extend by one bit, the top two sum bits disagree on overflow
  function automatic logic [rp_pkg::DAC_DW-1:0] sat_sum (
    input logic [rp_pkg::DAC_DW-1:0] gen,
    input logic [rp_pkg::DAC_DW-1:0] fb
  );
    logic [rp_pkg::SUM_DW-1:0] sum;
    sum = {gen[rp_pkg::DAC_DW-1], gen} + {fb[rp_pkg::DAC_DW-1], fb};
    if (sum[rp_pkg::SUM_DW-1] ^ sum[rp_pkg::SUM_DW-2]) begin
      // clip: 0x1fff on positive, 0x2000 on negative overflow
      sat_sum = {sum[rp_pkg::SUM_DW-1], {(rp_pkg::DAC_DW-1){~sum[rp_pkg::SUM_DW-1]}}};
    end else begin
      sat_sum = ~sum[rp_pkg::DAC_DW-1:0];  // converter wants inverted coding
    end
  endfunction

  assign loop_a_o = sat_sum(gen_a_i, fb_a_i);
  assign loop_b_o = sat_sum(gen_b_i, fb_b_i);

  ////////////////////////////////////////////////////////////////////////////
  // output pipe
  ////////////////////////////////////////////////////////////////////////////

  // stage 1, per channel
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_a_q <= '0;
      dac_b_q <= '0;
    end else begin
      dac_a_q <= loop_a_o;
      dac_b_q <= loop_b_o;
    end
  end

  // stage 2, channels swapped to match board routing
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_dat_a_o <= '0;
      dac_dat_b_o <= '0;
    end else begin
      dac_dat_a_o <= dac_b_q;  // ch b -> dac a
      dac_dat_b_o <= dac_a_q;  // ch a -> dac b
    end
  end

endmodule

/* adc_loopback_switch.sv */
// adc channel cross and digital loopback
// adc b feeds channel a and adc a feeds channel b on the board
// loopback takes the saturated dac words before their output registers
// two lsbs are dropped, samples are registered once

`timescale 1ns/100ps

module adc_loopback_switch (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,
  input  logic                      digital_loop_i,  // 1 = dac values back into acq
  input  logic [rp_pkg::ADC_DW-1:0] adc_raw_a_i,     // raw adc a word
  input  logic [rp_pkg::ADC_DW-1:0] adc_raw_b_i,     // raw adc b word
  input  logic [rp_pkg::DAC_DW-1:0] loop_a_i,        // saturated dac word ch a
  input  logic [rp_pkg::DAC_DW-1:0] loop_b_i,        // saturated dac word ch b
  output logic [rp_pkg::SMP_DW-1:0] smp_a_o,         // acq sample ch a
  output logic [rp_pkg::SMP_DW-1:0] smp_b_o          // acq sample ch b
);

  logic [rp_pkg::SMP_DW-1:0] sel_a;  // pre-register choice ch a
  logic [rp_pkg::SMP_DW-1:0] sel_b;  // pre-register choice ch b

  ////////////////////////////////////////////////////////////////////////////
  // source select
  ////////////////////////////////////////////////////////////////////////////

  // upper bits only, lsbs are below the noise floor anyway
  always_comb begin
    if (digital_loop_i) begin
      sel_a = loop_a_i[rp_pkg::DAC_DW-1 -: rp_pkg::SMP_DW];
      sel_b = loop_b_i[rp_pkg::DAC_DW-1 -: rp_pkg::SMP_DW];
    end else begin
      sel_a = adc_raw_b_i[rp_pkg::ADC_DW-1 -: rp_pkg::SMP_DW];  // adc b -> ch a
      sel_b = adc_raw_a_i[rp_pkg::ADC_DW-1 -: rp_pkg::SMP_DW];  // adc a -> ch b
    end
  end

  // sample register
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      smp_a_o <= '0;
      smp_b_o <= '0;
    end else begin
      smp_a_o <= sel_a;
      smp_b_o <= sel_b;
    end
  end

endmodule

/* pll_lock_monitor.sv */
// core reset gating and pll unlock diagnostics
// rst_n_i is assumed already synchronous to adc_clk
// core_rstn_o lags its inputs by one cycle, dac_reset_o by two
// unlock counter wraps silently, no saturation

`timescale 1ns/100ps

module pll_lock_monitor (
  input  logic                       adc_clk,
  input  logic                       rst_n_i,       // sync, active low
  input  logic                       pll_locked_i,  // pll lock status
  input  logic                       idly_rdy_i,    // input delay line ready
  output logic                       core_rstn_o,   // gated core reset, active low
  output logic                       dac_reset_o,   // converter reset, active high
  output logic [rp_pkg::DIAG_DW-1:0] unlock_cnt_o   // cycles seen without lock
);

  ////////////////////////////////////////////////////////////////////////////
  // reset gating
  ////////////////////////////////////////////////////////////////////////////

  // core only leaves reset once clocks and delay lines are usable
  always_ff @(posedge adc_clk) begin
    core_rstn_o <= rst_n_i & pll_locked_i & idly_rdy_i;
  end

  // dac reset follows core reset, one cycle behind
  always_ff @(posedge adc_clk) begin
    dac_reset_o <= ~core_rstn_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // unlock counter
  ////////////////////////////////////////////////////////////////////////////

  // only board reset clears it, so lock loss during run stays visible
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      unlock_cnt_o <= '0;
    end else if (!pll_locked_i) begin
      unlock_cnt_o <= unlock_cnt_o + rp_pkg::DIAG_STEP;  // wraps at max
    end
    // holds while locked
  end

endmodule

/* rp_pkg.sv */
// shared widths and fixed constants for the analog datapath
// everything runs in the single adc_clk domain
// widths are fixed here, the blocks carry no parameters
// daisy mode bit 1 is unused in this datapath

package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // converter and sample widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_DW  = 14;  // raw adc word
  localparam int unsigned SMP_DW  = 12;  // acquisition sample, top bits of adc word
  localparam int unsigned DAC_DW  = 14;  // generator, feedback and dac word
  localparam int unsigned SUM_DW  = 15;  // signed sum, one guard bit

  // diagnostics
  localparam int unsigned DIAG_DW = 32;  // pll unlock cycle counter
  localparam logic [DIAG_DW-1:0] DIAG_STEP = 1;  // counter increment

  ////////////////////////////////////////////////////////////////////////////
  // daisy chain and trigger
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned MODE_W   = 3;   // daisy mode config width
  localparam int unsigned DAISY_DW = 16;  // daisy parallel word

  // pattern sent when the link is not in sync mode
  localparam logic [DAISY_DW-1:0] DAISY_IDLE_WORD = 16'h1234;

  // daisy mode bit positions
  localparam int unsigned MODE_SYNC_BIT     = 0;  // sync mode, trigger over link
  localparam int unsigned MODE_TRIG_SEL_BIT = 2;  // 1 = generator trigger out

endpackage
